//--- srrc_rx.f
design/srrc_rx_pkg.sv
design/rx_clk_en_gen.sv
design/srrc_rx_flt.sv
design/sym_slicer.sv
design/srrc_rx_top.sv
test/srrc_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the srrc_rx testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module srrc_rx_tb -f srrc_rx.f \
    > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vsrrc_rx_tb > sim.log 2>&1 \
    || echo "simulation exited with an error status"
cat sim.log

grep -qx "Finished with no errors" sim.log \
    && exit 0 \
    || exit 1

//--- test/srrc_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module srrc_rx_tb;
    import srrc_rx_pkg::*;

    localparam int SAM_DIV    = 8;
    localparam int SYM_PHASE  = 2;
    localparam int WAIT_LIMIT = 4 * SAM_DIV;
    localparam int SEED       = 32'h69a1_5b02;

    logic    clk;
    logic    reset;
    sample_t sample_in;
    logic    sample_req;
    sample_t filt_out;
    sample_t sym_soft;
    sym_t    sym_out;
    logic    sym_valid;

    // model of the filter delay line, newest halved sample at index 0
    sample_t hist [NUM_TAPS];
    sample_t last_filt;
    int      sym_cnt;
    string   test_name;

    srrc_rx_top #(
        .SAM_DIV   (SAM_DIV),
        .SYM_PHASE (SYM_PHASE)
    ) i_srrc_rx_top (
        .clk        (clk),
        .reset      (reset),
        .in         (sample_in),
        .sample_req (sample_req),
        .filt_out   (filt_out),
        .sym_soft   (sym_soft),
        .sym_out    (sym_out),
        .sym_valid  (sym_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // mirrored pairs wrap to 18 bits, products keep bits 34:17
    function automatic sample_t filter_model(input sample_t h [NUM_TAPS]);
        sample_t acc;
        sample_t pair;
        sample_t kept;
        prod_t   prod;
        acc = '0;
        for (int k = 0; k < NUM_FOLD; k++) begin
            if (k == NUM_FOLD - 1) begin
                pair = h[k];
            end else begin
                pair = h[k] + h[NUM_TAPS-1-k];
            end
            prod = prod_t'(pair) * prod_t'(SRRC_COEF[k]);
            kept = prod[2*DATA_W-2:DATA_W-1];
            acc  = acc + kept;
        end
        return acc;
    endfunction

    function automatic sym_t slice_model(input sample_t v);
        int lvl;
        int thr;
        lvl = int'(v);
        thr = int'(SLICE_THRESH);
        if (lvl < -thr) begin
            return 2'b00;
        end else if (lvl < 0) begin
            return 2'b01;
        end else if (lvl < thr) begin
            return 2'b11;
        end
        return 2'b10;
    endfunction

    // idx 0..3 maps to -3, -1, +1, +3 times half the threshold
    function automatic sample_t pam_level(input int idx);
        return sample_t'((2 * idx - 3) * int'(SLICE_THRESH) / 2);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_sym(input string name, input sym_t exp, input sym_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_idle();
        check_flag({test_name, " sample_req"}, 1'b0, sample_req);
        check_flag({test_name, " sym_valid"}, 1'b0, sym_valid);
        check_sample({test_name, " filt_out"}, '0, filt_out);
        check_sample({test_name, " sym_soft"}, '0, sym_soft);
        check_sym({test_name, " sym_out"}, '0, sym_out);
    endtask

    // returns on the strobe edge, where the next input is presented
    task automatic wait_strobe();
        int n;
        n = 0;
        @(negedge clk);
        while (!sample_req) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run($sformatf("timeout waiting for sample_req in test %s", test_name));
            end
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic send_sample(input sample_t v);
        wait_strobe();
        sample_in <= v;
    endtask

    // filter checker, one compare per sample strobe
    initial begin : filt_checker
        sample_t exp;
        forever begin
            @(negedge clk);
            if (reset) begin
                for (int k = 0; k < NUM_TAPS; k++) begin
                    hist[k] = '0;
                end
                last_filt = '0;
            end else if (sample_req) begin
                exp = filter_model(hist);
                for (int k = NUM_TAPS - 1; k > 0; k--) begin
                    hist[k] = hist[k-1];
                end
                hist[0] = sample_in >>> 1;
                @(negedge clk);
                check_sample({test_name, " filt_out"}, exp, filt_out);
                last_filt = exp;
            end
        end
    end

    // symbol checker, cadence and decisions
    initial begin : sym_checker
        int   strobe_idx;
        int   since;
        logic due;
        logic prev_valid;
        strobe_idx = 0;
        since = 0;
        due = 1'b0;
        prev_valid = 1'b0;
        sym_cnt = 0;
        forever begin
            @(negedge clk);
            if (reset) begin
                strobe_idx = 0;
                due = 1'b0;
                prev_valid = 1'b0;
            end else begin
                if (due) begin
                    since++;
                end
                if (sym_valid) begin
                    if (prev_valid) begin
                        abort_run("sym_valid was high on two consecutive cycles");
                    end
                    if (!due) begin
                        abort_run("sym_valid pulsed without a symbol strobe");
                    end
                    check_count({test_name, " sym_valid delay"}, 2, since);
                    check_sample({test_name, " sym_soft"}, last_filt, sym_soft);
                    check_sym({test_name, " sym_out"}, slice_model(last_filt), sym_out);
                    due = 1'b0;
                    sym_cnt++;
                end
                if (sample_req) begin
                    if (due) begin
                        abort_run("sym_valid never came for the previous symbol strobe");
                    end
                    if (strobe_idx % SAMPLES_PER_SYM == SYM_PHASE) begin
                        due = 1'b1;
                        since = 0;
                    end
                    strobe_idx++;
                end
                prev_valid = sym_valid;
            end
        end
    end

    initial begin : main_seq
        int      n;
        int      sym_before;
        sample_t v;
        void'($urandom(SEED));
        reset = 1'b1;
        sample_in = '0;
        test_name = "reset";

        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        reset <= 1'b0;

        // idle until the first sample strobe
        n = 0;
        @(negedge clk);
        while (!sample_req) begin
            check_idle();
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("timeout waiting for the first sample_req after reset");
            end
            @(negedge clk);
        end

        test_name = "impulse";
        send_sample(18'sd131071);
        repeat (40) send_sample('0);

        test_name = "random";
        for (int i = 0; i < 400; i++) begin
            if (i % 100 < 12) begin
                v = ((i / 100) % 2 == 0) ? 18'sh1ffff : 18'sh20000;
            end else begin
                v = sample_t'($urandom);
            end
            send_sample(v);
        end

        test_name = "cadence";
        send_sample('0);
        sym_before = sym_cnt;
        repeat (64) send_sample('0);
        check_count("cadence symbols per 64 samples", 16, sym_cnt - sym_before);

        test_name = "decision";
        for (int s = 0; s < 200; s++) begin
            send_sample(pam_level(int'($urandom % 4)));
            repeat (SAMPLES_PER_SYM - 1) send_sample('0);
        end
        repeat (40) send_sample('0);

        repeat (4) @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/srrc_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module srrc_rx_top #(
    parameter int SAM_DIV   = 8,
    parameter int SYM_PHASE = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  srrc_rx_pkg::sample_t in,
    output logic                 sample_req,
    output srrc_rx_pkg::sample_t filt_out,
    output srrc_rx_pkg::sample_t sym_soft,
    output srrc_rx_pkg::sym_t    sym_out,
    output logic                 sym_valid
);

    logic sym_clk_en;

    // sample strobe doubles as the source request
    rx_clk_en_gen #(
        .SAM_DIV   (SAM_DIV),
        .SYM_PHASE (SYM_PHASE)
    ) i_rx_clk_en_gen (
        .clk        (clk),
        .reset      (reset),
        .sam_clk_en (sample_req),
        .sym_clk_en (sym_clk_en)
    );

    srrc_rx_flt i_srrc_rx_flt (
        .clk        (clk),
        .reset      (reset),
        .sam_clk_en (sample_req),
        .in         (in),
        .out        (filt_out)
    );

    sym_slicer i_sym_slicer (
        .clk        (clk),
        .reset      (reset),
        .sym_clk_en (sym_clk_en),
        .filt_in    (filt_out),
        .sym_soft   (sym_soft),
        .sym_out    (sym_out),
        .sym_valid  (sym_valid)
    );

endmodule

`default_nettype wire

//--- design/sym_slicer.sv
`timescale 1ns/1ps
`default_nettype none

module sym_slicer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sym_clk_en,
    input  srrc_rx_pkg::sample_t filt_in,
    output srrc_rx_pkg::sample_t sym_soft,
    output srrc_rx_pkg::sym_t    sym_out,
    output logic                 sym_valid
);
    import srrc_rx_pkg::*;

    logic sym_dly;
    sym_t sym_dec;

    // threshold decision, gray order 00 01 11 10
    always_comb begin
        if (filt_in < -SLICE_THRESH) begin
            sym_dec = 2'b00;
        end else if (filt_in < 0) begin
            sym_dec = 2'b01;
        end else if (filt_in < SLICE_THRESH) begin
            sym_dec = 2'b11;
        end else begin
            sym_dec = 2'b10;
        end
    end

    // filter output updates on the strobe edge, so sample one cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sym_dly   <= 1'b0;
            sym_valid <= 1'b0;
            sym_soft  <= '0;
            sym_out   <= '0;
        end else begin
            sym_dly   <= sym_clk_en;
            sym_valid <= sym_dly;
            if (sym_dly) begin
                sym_soft <= filt_in;
                sym_out  <= sym_dec;
            end
        end
    end

    a_valid_single: assert property (@(posedge clk) disable iff (reset)
        sym_valid |=> !sym_valid);

endmodule

`default_nettype wire

//--- design/srrc_rx_flt.sv
`timescale 1ns/1ps
`default_nettype none

module srrc_rx_flt (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sam_clk_en,
    input  srrc_rx_pkg::sample_t in,
    output srrc_rx_pkg::sample_t out
);
    import srrc_rx_pkg::*;

    // pre-add, multiply and two tree levels
    localparam int PIPE_LVLS = 4;
    localparam int L1_N = (NUM_FOLD + 1) / 2;
    localparam int L2_N = (L1_N + 1) / 2;

    sample_t x [NUM_TAPS];
    sample_t pre_sum [NUM_FOLD];
    prod_t   mult_out [NUM_FOLD];
    sample_t prod_trunc [NUM_FOLD];
    sample_t sum_l1 [L1_N];
    sample_t sum_l2 [L2_N];
    sample_t tree_sum;

    logic [PIPE_LVLS-1:0] stb_hist;

    // delay line, input halved
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                x[i] <= '0;
            end
        end else if (sam_clk_en) begin
            x[0] <= in >>> 1;
            for (int i = 1; i < NUM_TAPS; i++) begin
                x[i] <= x[i-1];
            end
        end
    end

    // fold mirrored taps, centre tap passes alone
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_FOLD; i++) begin
                pre_sum[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_FOLD - 1; i++) begin
                pre_sum[i] <= x[i] + x[NUM_TAPS-1-i];
            end
            pre_sum[NUM_FOLD-1] <= x[NUM_FOLD-1];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_FOLD; i++) begin
                mult_out[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_FOLD; i++) begin
                mult_out[i] <= prod_t'(pre_sum[i]) * prod_t'(SRRC_COEF[i]);
            end
        end
    end

    // back to Q1.17
    always_comb begin
        for (int i = 0; i < NUM_FOLD; i++) begin
            prod_trunc[i] = mult_out[i][PROD_LSB+DATA_W-1:PROD_LSB];
        end
    end

    // first tree level, odd product passes through
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < L1_N; i++) begin
                sum_l1[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_FOLD / 2; i++) begin
                sum_l1[i] <= prod_trunc[2*i] + prod_trunc[2*i+1];
            end
            if (NUM_FOLD % 2 != 0) begin
                sum_l1[L1_N-1] <= prod_trunc[NUM_FOLD-1];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < L2_N; i++) begin
                sum_l2[i] <= '0;
            end
        end else begin
            for (int i = 0; i < L1_N / 2; i++) begin
                sum_l2[i] <= sum_l1[2*i] + sum_l1[2*i+1];
            end
            if (L1_N % 2 != 0) begin
                sum_l2[L2_N-1] <= sum_l1[L1_N-1];
            end
        end
    end

    // remaining levels settle before the next strobe
    always_comb begin
        tree_sum = '0;
        for (int i = 0; i < L2_N; i++) begin
            tree_sum = tree_sum + sum_l2[i];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out <= '0;
        end else if (sam_clk_en) begin
            out <= tree_sum;
        end
    end

    // recent strobes, for the spacing check
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stb_hist <= '0;
        end else begin
            stb_hist <= {stb_hist[PIPE_LVLS-2:0], sam_clk_en};
        end
    end

    // the tree must have settled from the previous shift
    a_strobe_spacing: assert property (@(posedge clk) disable iff (reset)
        sam_clk_en |-> (stb_hist == '0));

endmodule

`default_nettype wire

//--- design/rx_clk_en_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rx_clk_en_gen #(
    parameter int SAM_DIV   = 8,
    parameter int SYM_PHASE = 0
) (
    input  logic clk,
    input  logic reset,
    output logic sam_clk_en,
    output logic sym_clk_en
);
    import srrc_rx_pkg::*;

    localparam int DIV_W = (SAM_DIV > 1) ? $clog2(SAM_DIV) : 1;
    localparam int PH_W  = $clog2(SAMPLES_PER_SYM);

    logic [DIV_W-1:0] div_cnt;
    logic [PH_W-1:0]  ph_cnt;
    logic             div_wrap;

    assign div_wrap = (div_cnt == DIV_W'(SAM_DIV - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt    <= '0;
            ph_cnt     <= '0;
            sam_clk_en <= 1'b0;
            sym_clk_en <= 1'b0;
        end else begin
            div_cnt    <= div_wrap ? '0 : div_cnt + 1'b1;
            sam_clk_en <= div_wrap;
            // strobe k carries phase k mod 4
            sym_clk_en <= div_wrap && (ph_cnt == PH_W'(SYM_PHASE));
            if (sam_clk_en) begin
                ph_cnt <= (ph_cnt == PH_W'(SAMPLES_PER_SYM - 1)) ? '0 : ph_cnt + 1'b1;
            end
        end
    end

    a_phase_range: assert property (@(posedge clk) SYM_PHASE < SAMPLES_PER_SYM);

    // next symbol strobe lands on the sample strobe one symbol later
    a_sym_period: assert property (@(posedge clk) disable iff (reset)
        $past(sym_clk_en, SAM_DIV * SAMPLES_PER_SYM) |-> (sym_clk_en && sam_clk_en));

endmodule

`default_nettype wire

//--- design/srrc_rx_pkg.sv
`default_nettype none

package srrc_rx_pkg;

    // sample, coefficient and filter sum width
    localparam int DATA_W = 18;

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic signed [2*DATA_W-1:0] prod_t;

    // product bits kept after a multiply, 34 down to 17
    localparam int PROD_LSB = DATA_W - 1;

    localparam int NUM_TAPS = 33;
    localparam int NUM_FOLD = (NUM_TAPS + 1) / 2;
    localparam int SAMPLES_PER_SYM = 4;

    // first half of the srrc response, beta 0.5, 4 samples per symbol
    // outermost tap first, centre tap last, Q1.17
    localparam sample_t SRRC_COEF [NUM_FOLD] = '{
        -18'sd583,
        -18'sd220,
        18'sd618,
        18'sd949,
        18'sd175,
        -18'sd949,
        -18'sd865,
        18'sd892,
        18'sd2447,
        18'sd892,
        -18'sd4326,
        -18'sd9043,
        -18'sd6118,
        18'sd9043,
        18'sd33363,
        18'sd56188,
        18'sd65536
    };

    // outer decision level, twice the inner symbol level (0.25 in Q1.17)
    localparam sample_t SLICE_THRESH = 18'sd32768;

    // gray coded 4-PAM decision, most negative first: 00 01 11 10
    typedef logic [1:0] sym_t;

endpackage

`default_nettype wire
